// ==== flist.f ====
mem_pkg.sv
mem_cmd_router.sv
xui_bridge.sv
xui_block_ram.sv
mem_resp_arbiter.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

// ==== mem_cmd_router.sv ====
// ############################
// steers a command to one of the memory channels.
// the channel sits just above the block offset.
// ############################
`timescale 1ns/1ps
`default_nettype none

module mem_cmd_router
  import mem_pkg::*;
(
  input  wire                    clk_i,
  input  wire                    reset_i,
  input  mem_addr_t              cmd_addr_i,
  input  wire                    cmd_v_i,
  output logic                   cmd_ready_o,
  output logic [NUM_CHANNELS-1:0] chan_v_o,
  input  wire  [NUM_CHANNELS-1:0] chan_ready_i
);

  chan_id_t cmd_chan;

  assign cmd_chan = cmd_addr_i[BLOCK_OFFSET_BITS +: CHAN_BITS];

  // only the addressed channel sees valid.
  always_comb begin
    chan_v_o = '0;
    if (cmd_v_i) begin
      chan_v_o[cmd_chan] = 1'b1;
    end
  end

  assign cmd_ready_o = chan_ready_i[cmd_chan];

  // a command never reaches two channels at once.
  chan_v_onehot_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    $onehot0(chan_v_o)
  );

endmodule

`default_nettype wire

// ==== mem_pkg.sv ====
// ############################
// shared widths, types and encodings for the memory port.
// imported by every RTL module of the subsystem.
// ############################
`default_nettype none

package mem_pkg;

  localparam int ADDR_WIDTH        = 12;
  localparam int BLOCK_WIDTH       = 64;
  localparam int BLOCK_OFFSET_BITS = 3;
  localparam int NUM_CHANNELS      = 4;
  localparam int CHAN_BITS         = 2;
  localparam int ROW_BITS          = 7;
  localparam int READ_LATENCY      = 3;
  localparam int TAG_WIDTH         = 4;

  typedef logic [ADDR_WIDTH-1:0]  mem_addr_t;
  typedef logic [BLOCK_WIDTH-1:0] mem_data_t;
  typedef logic                   mem_op_t;
  typedef logic [TAG_WIDTH-1:0]   mem_tag_t;
  typedef logic [CHAN_BITS-1:0]   chan_id_t;
  typedef logic [ROW_BITS-1:0]    row_t;

  localparam mem_op_t OP_RD = 1'b0;
  localparam mem_op_t OP_WR = 1'b1;

  // controller user interface command codes.
  typedef logic [2:0] app_cmd_t;

  localparam app_cmd_t APP_CMD_WR = 3'b000;
  localparam app_cmd_t APP_CMD_RD = 3'b001;

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_READ_WAIT,
    BR_RESP_RD,
    BR_RESP_WR
  } bridge_state_e;

endpackage

`default_nettype wire

// ==== mem_resp_arbiter.sv ====
// ############################
// round-robin merge of the channel responses.
// grant stays put until the response is taken.
// ############################
`timescale 1ns/1ps
`default_nettype none

module mem_resp_arbiter
  import mem_pkg::*;
(
  input  wire                     clk_i,
  input  wire                     reset_i,
  input  wire  [NUM_CHANNELS-1:0] chan_v_i,
  input  mem_addr_t               chan_addr_i [NUM_CHANNELS],
  input  mem_op_t                 chan_op_i   [NUM_CHANNELS],
  input  mem_tag_t                chan_tag_i  [NUM_CHANNELS],
  input  mem_data_t               chan_data_i [NUM_CHANNELS],
  output logic [NUM_CHANNELS-1:0] chan_yumi_o,
  output mem_addr_t               resp_addr_o,
  output mem_op_t                 resp_op_o,
  output mem_tag_t                resp_tag_o,
  output mem_data_t               resp_data_o,
  output logic                    resp_v_o,
  input  wire                     resp_yumi_i
);

  chan_id_t last_q;
  chan_id_t hold_chan_q;
  logic     hold_q;
  chan_id_t rr_pick;
  chan_id_t rr_idx;
  logic     rr_found;
  chan_id_t sel;

  // search starts just after the last channel served.
  always_comb begin
    rr_pick  = last_q;
    rr_found = 1'b0;
    rr_idx   = last_q;
    for (int i = 1; i <= NUM_CHANNELS; i++) begin
      rr_idx = chan_id_t'(last_q + i);
      if (!rr_found && chan_v_i[rr_idx]) begin
        rr_pick  = rr_idx;
        rr_found = 1'b1;
      end
    end
  end

  assign sel = hold_q ? hold_chan_q : rr_pick;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_q      <= chan_id_t'(NUM_CHANNELS - 1);
      hold_q      <= 1'b0;
      hold_chan_q <= '0;
    end else if (resp_v_o && resp_yumi_i) begin
      last_q <= sel;
      hold_q <= 1'b0;
    end else if (resp_v_o) begin
      hold_q      <= 1'b1;
      hold_chan_q <= sel;
    end
  end

  assign resp_v_o    = chan_v_i[sel];
  assign resp_addr_o = chan_addr_i[sel];
  assign resp_op_o   = chan_op_i[sel];
  assign resp_tag_o  = chan_tag_i[sel];
  assign resp_data_o = chan_data_i[sel];

  always_comb begin
    chan_yumi_o = '0;
    chan_yumi_o[sel] = resp_yumi_i;
  end

  // a shown response holds until it is consumed.
  resp_stable_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (resp_v_o && !resp_yumi_i) |=> (resp_v_o && $stable(resp_addr_o) && $stable(resp_op_o)
      && $stable(resp_tag_o) && $stable(resp_data_o))
  );

endmodule

`default_nettype wire

// ==== mem_subsystem_top.sv ====
// ############################
// four-channel memory port: router, bridge and ram pairs,
// and the response arbiter. instantiate as the DUT.
// ############################
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top
  import mem_pkg::*;
(
  input  wire       clk_i,
  input  wire       reset_i,
  input  mem_addr_t cmd_addr_i,
  input  mem_op_t   cmd_op_i,
  input  mem_tag_t  cmd_tag_i,
  input  mem_data_t cmd_data_i,
  input  wire       cmd_v_i,
  output logic      cmd_ready_o,
  output mem_addr_t resp_addr_o,
  output mem_op_t   resp_op_o,
  output mem_tag_t  resp_tag_o,
  output mem_data_t resp_data_o,
  output logic      resp_v_o,
  input  wire       resp_yumi_i
);

  logic [NUM_CHANNELS-1:0] chan_cmd_v;
  logic [NUM_CHANNELS-1:0] chan_cmd_ready;
  logic [NUM_CHANNELS-1:0] chan_resp_v;
  logic [NUM_CHANNELS-1:0] chan_resp_yumi;
  mem_addr_t               chan_resp_addr [NUM_CHANNELS];
  mem_op_t                 chan_resp_op   [NUM_CHANNELS];
  mem_tag_t                chan_resp_tag  [NUM_CHANNELS];
  mem_data_t               chan_resp_data [NUM_CHANNELS];

  mem_cmd_router router0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_v_i      (cmd_v_i),
    .cmd_ready_o  (cmd_ready_o),
    .chan_v_o     (chan_cmd_v),
    .chan_ready_i (chan_cmd_ready)
  );

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
    row_t      app_addr;
    app_cmd_t  app_cmd;
    logic      app_en;
    logic      app_rdy;
    logic      app_wdf_wren;
    mem_data_t app_wdf_data;
    logic      app_wdf_end;
    logic      app_wdf_rdy;
    logic      app_rd_data_valid;
    mem_data_t app_rd_data;

    xui_bridge bridge (
      .clk_i (clk_i), .reset_i (reset_i),
      .cmd_addr_i (cmd_addr_i), .cmd_op_i (cmd_op_i),
      .cmd_tag_i (cmd_tag_i), .cmd_data_i (cmd_data_i),
      .cmd_v_i (chan_cmd_v[i]), .cmd_ready_o (chan_cmd_ready[i]),
      .app_addr_o (app_addr), .app_cmd_o (app_cmd), .app_en_o (app_en),
      .app_rdy_i (app_rdy), .app_wdf_wren_o (app_wdf_wren),
      .app_wdf_data_o (app_wdf_data), .app_wdf_end_o (app_wdf_end),
      .app_wdf_rdy_i (app_wdf_rdy), .app_rd_data_valid_i (app_rd_data_valid),
      .app_rd_data_i (app_rd_data),
      .resp_addr_o (chan_resp_addr[i]), .resp_op_o (chan_resp_op[i]),
      .resp_tag_o (chan_resp_tag[i]), .resp_data_o (chan_resp_data[i]),
      .resp_v_o (chan_resp_v[i]), .resp_yumi_i (chan_resp_yumi[i])
    );

    xui_block_ram ram (
      .clk_i (clk_i), .reset_i (reset_i),
      .app_addr_i (app_addr), .app_cmd_i (app_cmd), .app_en_i (app_en),
      .app_rdy_o (app_rdy), .app_wdf_wren_i (app_wdf_wren),
      .app_wdf_data_i (app_wdf_data), .app_wdf_end_i (app_wdf_end),
      .app_wdf_rdy_o (app_wdf_rdy), .app_rd_data_valid_o (app_rd_data_valid),
      .app_rd_data_o (app_rd_data)
    );
  end

  mem_resp_arbiter arbiter0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .chan_v_i    (chan_resp_v),
    .chan_addr_i (chan_resp_addr),
    .chan_op_i   (chan_resp_op),
    .chan_tag_i  (chan_resp_tag),
    .chan_data_i (chan_resp_data),
    .chan_yumi_o (chan_resp_yumi),
    .resp_addr_o (resp_addr_o),
    .resp_op_o   (resp_op_o),
    .resp_tag_o  (resp_tag_o),
    .resp_data_o (resp_data_o),
    .resp_v_o    (resp_v_o),
    .resp_yumi_i (resp_yumi_i)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run with Verilator; status follows the testbench verdict.
verilator --binary --timing --assert -j 0 --top-module tb_mem_subsystem \
  -f flist.f -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Everything OK" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// ==== tb_mem_subsystem.sv ====
// ############################
// testbench for the four-channel memory port.
// random traffic against a reference memory, checked by assertions.
// ############################
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem
  import mem_pkg::*;
;

  logic      clk_i;
  logic      reset_i;
  mem_addr_t cmd_addr_i;
  mem_op_t   cmd_op_i;
  mem_tag_t  cmd_tag_i;
  mem_data_t cmd_data_i;
  logic      cmd_v_i;
  wire       cmd_ready_o;
  mem_addr_t resp_addr_o;
  mem_op_t   resp_op_o;
  mem_tag_t  resp_tag_o;
  mem_data_t resp_data_o;
  wire       resp_v_o;
  logic      resp_yumi_i;

  logic [31:0] lfsr_q;
  mem_data_t   ref_mem [512];
  logic        pending [16];
  mem_addr_t   exp_addr [16];
  mem_op_t     exp_op [16];
  mem_data_t   exp_data [16];
  int          pending_cnt;
  int          resp_cnt;
  int          errors;
  int          err_mark;
  int          tests_run;
  mem_tag_t    next_tag;
  logic        yumi_en;
  logic        stall_mode;
  logic        yumi_ok;

  mem_subsystem_top dut0 (
    .clk_i (clk_i), .reset_i (reset_i),
    .cmd_addr_i (cmd_addr_i), .cmd_op_i (cmd_op_i), .cmd_tag_i (cmd_tag_i),
    .cmd_data_i (cmd_data_i), .cmd_v_i (cmd_v_i), .cmd_ready_o (cmd_ready_o),
    .resp_addr_o (resp_addr_o), .resp_op_o (resp_op_o), .resp_tag_o (resp_tag_o),
    .resp_data_o (resp_data_o), .resp_v_o (resp_v_o), .resp_yumi_i (resp_yumi_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // fibonacci lfsr, taps 32 22 2 1.
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  task automatic fail_check(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic abort_run(input string msg);
    $display("timeout at %0t: %s", $time, msg);
    $display("Something failed");
    $finish;
  endtask

  // held responses must not move until taken.
  resp_hold_a : assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_o && !resp_yumi_i) |=> (resp_v_o && $stable(resp_addr_o) && $stable(resp_op_o)
      && $stable(resp_tag_o) && $stable(resp_data_o)))
    else fail_check("response changed or dropped before yumi");

  reset_idle_a : assert property (@(posedge clk_i)
    reset_i |=> (!resp_v_o && !cmd_ready_o))
    else fail_check("outputs active right after reset");

  // yumi decided mid-cycle, driven after the next rising edge.
  always begin
    @(negedge clk_i);
    yumi_ok = yumi_en && !reset_i;
    if (yumi_ok && stall_mode) begin
      yumi_ok = (take_bits(2) == 64'd0);
    end
    @(posedge clk_i);
    #1;
    resp_yumi_i = yumi_ok && resp_v_o;
  end

  // scoreboard, sampled mid-cycle.
  always @(negedge clk_i) begin
    if (!reset_i && resp_v_o && resp_yumi_i) begin
      assert (pending[resp_tag_o]) else fail_check("response for a tag not in flight");
      assert (resp_addr_o == exp_addr[resp_tag_o]) else fail_check("address not echoed");
      assert (resp_op_o == exp_op[resp_tag_o]) else fail_check("op not echoed");
      assert (resp_data_o == exp_data[resp_tag_o]) else fail_check("response data mismatch");
      pending[resp_tag_o] = 1'b0;
      pending_cnt--;
      resp_cnt++;
    end
    if (!reset_i && cmd_v_i && cmd_ready_o) begin
      assert (!pending[cmd_tag_i]) else fail_check("tag issued twice");
      if (cmd_op_i == OP_WR) begin
        ref_mem[cmd_addr_i[11:3]] = cmd_data_i;
      end
      pending[cmd_tag_i]  = 1'b1;
      exp_addr[cmd_tag_i] = cmd_addr_i;
      exp_op[cmd_tag_i]   = cmd_op_i;
      exp_data[cmd_tag_i] = (cmd_op_i == OP_WR) ? '0 : ref_mem[cmd_addr_i[11:3]];
      pending_cnt++;
    end
  end

  // starts and ends 1 ns after a rising edge.
  task automatic send_cmd(input mem_addr_t addr, input mem_op_t op, input mem_data_t data);
    int cnt;
    cnt = 0;
    while (pending[next_tag]) begin
      next_tag++;
    end
    cmd_addr_i = addr;
    cmd_op_i   = op;
    cmd_tag_i  = next_tag;
    cmd_data_i = data;
    cmd_v_i    = 1'b1;
    next_tag++;
    forever begin
      @(negedge clk_i);
      if (cmd_ready_o) begin
        break;
      end
      cnt++;
      if (cnt > 500) begin
        abort_run("command never accepted");
      end
    end
    @(posedge clk_i);
    #1;
    cmd_v_i = 1'b0;
  endtask

  task automatic drain();
    int cnt;
    cnt = 0;
    while (pending_cnt != 0) begin
      @(posedge clk_i);
      #1;
      cnt++;
      if (cnt > 3000) begin
        abort_run("responses lost, drain never finished");
      end
    end
  endtask

  task automatic random_traffic(input int n, input logic writes_only);
    logic [63:0] bits;
    mem_addr_t   addr;
    mem_op_t     op;
    for (int i = 0; i < n; i++) begin
      bits = take_bits(9);
      addr = {bits[8:0], 3'b000};
      op = writes_only ? OP_WR : mem_op_t'(take_bits(1));
      send_cmd(addr, op, take_bits(64));
    end
  endtask

  task automatic random_reads(input int n);
    logic [63:0] bits;
    for (int i = 0; i < n; i++) begin
      bits = take_bits(9);
      send_cmd({bits[8:0], 3'b000}, OP_RD, '0);
    end
  endtask

  task automatic measure_latency(input mem_addr_t addr, input mem_op_t op, input int expect_n);
    int n;
    n = 1;
    send_cmd(addr, op, take_bits(64));
    forever begin
      @(negedge clk_i);
      if (resp_v_o) begin
        break;
      end
      n++;
      if (n > 50) begin
        abort_run("no response for single command");
      end
    end
    assert (n == expect_n) else fail_check("single command latency off");
    @(posedge clk_i);
    #1;
    drain();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("test %0d %s done, %0d new errors", tests_run, name, errors - err_mark);
    err_mark = errors;
  endtask

  initial begin
    lfsr_q = 32'hf131_2e9c;
    reset_i = 1'b1;
    cmd_addr_i = '0;
    cmd_op_i = OP_RD;
    cmd_tag_i = '0;
    cmd_data_i = '0;
    cmd_v_i = 1'b0;
    resp_yumi_i = 1'b0;
    yumi_en = 1'b1;
    stall_mode = 1'b0;
    next_tag = '0;
    pending_cnt = 0;
    resp_cnt = 0;
    errors = 0;
    err_mark = 0;
    tests_run = 0;
    for (int i = 0; i < 16; i++) begin
      pending[i] = 1'b0;
    end
    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // ram model comes up one cycle after reset.
    repeat (2) @(posedge clk_i);
    for (int i = 0; i < 8; i++) begin
      @(negedge clk_i);
      assert (!resp_v_o && cmd_ready_o) else fail_check("port not idle after reset");
    end
    @(posedge clk_i);
    #1;
    end_test("reset idle");

    for (int b = 0; b < 512; b++) begin
      send_cmd(mem_addr_t'(b * 8), OP_WR, take_bits(64));
    end
    random_traffic(40, 1'b1);
    random_reads(40);
    drain();
    end_test("write and read back");

    random_traffic(60, 1'b0);
    drain();
    end_test("header echo");

    stall_mode = 1'b1;
    random_traffic(60, 1'b0);
    drain();
    stall_mode = 1'b0;
    end_test("response back-pressure");

    measure_latency(12'h150, OP_WR, 1);
    measure_latency(12'h150, OP_RD, 4);
    end_test("uncontended latency");

    yumi_en = 1'b0;
    send_cmd(12'h200, OP_WR, take_bits(64));
    cmd_addr_i = 12'h240;
    cmd_op_i   = OP_RD;
    cmd_v_i    = 1'b1;
    for (int i = 0; i < 6; i++) begin
      @(negedge clk_i);
      assert (!cmd_ready_o) else fail_check("busy channel accepted a command");
    end
    @(posedge clk_i);
    #1;
    cmd_v_i = 1'b0;
    send_cmd(12'h208, OP_WR, take_bits(64));
    send_cmd(12'h210, OP_RD, '0);
    send_cmd(12'h218, OP_WR, take_bits(64));
    yumi_en = 1'b1;
    drain();
    end_test("per-channel stall");

    $display("tests %0d, responses %0d, errors %0d", tests_run, resp_cnt, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== xui_block_ram.sv ====
// ############################
// block-ram model of the controller user interface.
// fixed read latency, stalls while a read is in flight.
// ############################
`timescale 1ns/1ps
`default_nettype none

module xui_block_ram
  import mem_pkg::*;
(
  input  wire       clk_i,
  input  wire       reset_i,
  input  row_t      app_addr_i,
  input  app_cmd_t  app_cmd_i,
  input  wire       app_en_i,
  output logic      app_rdy_o,
  input  wire       app_wdf_wren_i,
  input  mem_data_t app_wdf_data_i,
  input  wire       app_wdf_end_i,
  output logic      app_wdf_rdy_o,
  output logic      app_rd_data_valid_o,
  output mem_data_t app_rd_data_o
);

  mem_data_t               mem_q [2**ROW_BITS];
  mem_data_t               rd_pipe_q [READ_LATENCY];
  logic [READ_LATENCY-1:0] rd_vld_q;
  logic                    up_q;
  logic                    wr_fire;
  logic                    rd_fire;

  assign app_rdy_o     = up_q & ~(|rd_vld_q);
  assign app_wdf_rdy_o = up_q;

  assign wr_fire = app_en_i & app_rdy_o & app_wdf_wren_i & app_wdf_end_i;
  assign rd_fire = app_en_i & app_rdy_o & (app_cmd_i == APP_CMD_RD);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      up_q     <= 1'b0;
      rd_vld_q <= '0;
    end else begin
      up_q     <= 1'b1;
      rd_vld_q <= {rd_vld_q[READ_LATENCY-2:0], rd_fire};
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      mem_q[app_addr_i] <= app_wdf_data_i;
    end
  end

  // data walks alongside the valid bits.
  always_ff @(posedge clk_i) begin
    rd_pipe_q[0] <= mem_q[app_addr_i];
    for (int i = 1; i < READ_LATENCY; i++) begin
      rd_pipe_q[i] <= rd_pipe_q[i-1];
    end
  end

  assign app_rd_data_valid_o = rd_vld_q[READ_LATENCY-1];
  assign app_rd_data_o       = rd_pipe_q[READ_LATENCY-1];

  // write data only alongside a write request.
  wren_with_write_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    app_wdf_wren_i |-> (app_en_i && app_cmd_i == APP_CMD_WR)
  );

endmodule

`default_nettype wire

// ==== xui_bridge.sv ====
// ############################
// converts one channel's commands to the controller user
// interface and holds the response until it is taken.
// ############################
`timescale 1ns/1ps
`default_nettype none

module xui_bridge
  import mem_pkg::*;
(
  input  wire       clk_i,
  input  wire       reset_i,

  input  mem_addr_t cmd_addr_i,
  input  mem_op_t   cmd_op_i,
  input  mem_tag_t  cmd_tag_i,
  input  mem_data_t cmd_data_i,
  input  wire       cmd_v_i,
  output logic      cmd_ready_o,

  output row_t      app_addr_o,
  output app_cmd_t  app_cmd_o,
  output logic      app_en_o,
  input  wire       app_rdy_i,
  output logic      app_wdf_wren_o,
  output mem_data_t app_wdf_data_o,
  output logic      app_wdf_end_o,
  input  wire       app_wdf_rdy_i,
  input  wire       app_rd_data_valid_i,
  input  mem_data_t app_rd_data_i,

  output mem_addr_t resp_addr_o,
  output mem_op_t   resp_op_o,
  output mem_tag_t  resp_tag_o,
  output mem_data_t resp_data_o,
  output logic      resp_v_o,
  input  wire       resp_yumi_i
);

  bridge_state_e state_q;
  logic          accept;
  mem_addr_t     hdr_addr_q;
  mem_op_t       hdr_op_q;
  mem_tag_t      hdr_tag_q;
  mem_data_t     rd_data_q;

  assign cmd_ready_o = (state_q == BR_IDLE) & app_rdy_i & app_wdf_rdy_i;
  assign accept      = cmd_v_i & cmd_ready_o;

  // request goes out in the same cycle it is accepted.
  assign app_en_o       = accept;
  assign app_addr_o     = cmd_addr_i[BLOCK_OFFSET_BITS+CHAN_BITS +: ROW_BITS];
  assign app_cmd_o      = (cmd_op_i == OP_RD) ? APP_CMD_RD : APP_CMD_WR;
  assign app_wdf_wren_o = accept & (cmd_op_i == OP_WR);
  assign app_wdf_data_o = cmd_data_i;
  assign app_wdf_end_o  = app_wdf_wren_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= BR_IDLE;
    end else begin
      case (state_q)
        BR_IDLE:
          if (accept) begin
            state_q <= (cmd_op_i == OP_RD) ? BR_READ_WAIT : BR_RESP_WR;
          end
        BR_READ_WAIT:
          if (app_rd_data_valid_i) begin
            state_q <= BR_RESP_RD;
          end
        default:
          if (resp_yumi_i) begin
            state_q <= BR_IDLE;
          end
      endcase
    end
  end

  // header kept for the response.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      hdr_addr_q <= cmd_addr_i;
      hdr_op_q   <= cmd_op_i;
      hdr_tag_q  <= cmd_tag_i;
    end
    if (app_rd_data_valid_i) begin
      rd_data_q <= app_rd_data_i;
    end
  end

  assign resp_v_o    = (state_q == BR_RESP_RD) | (state_q == BR_RESP_WR);
  assign resp_addr_o = hdr_addr_q;
  assign resp_op_o   = hdr_op_q;
  assign resp_tag_o  = hdr_tag_q;
  assign resp_data_o = (state_q == BR_RESP_RD) ? rd_data_q : '0;

  // ram only returns data for a read this bridge issued.
  rd_valid_in_wait_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    app_rd_data_valid_i |-> (state_q == BR_READ_WAIT)
  );

  // the arbiter only consumes a response that is shown.
  yumi_when_valid_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    resp_yumi_i |-> resp_v_o
  );

endmodule

`default_nettype wire
